// File: opl_slot_config.svh
// sizes and field widths for the FM operator slot engine
`ifndef OPL_SLOT_CONFIG_SVH
`define OPL_SLOT_CONFIG_SVH

`define OPL_NUM_SLOTS     18  // operator slots per sample
`define OPL_NUM_CHANNELS  9
`define OPL_SLOT_CYCLES   7   // clocks per slot window
`define OPL_OP_PIPE       3   // operator latency
`define OPL_FNUM_W        10
`define OPL_BLOCK_W       3
`define OPL_MULT_W        4
`define OPL_FB_W          3
`define OPL_PHASE_W       20
`define OPL_OUT_W         12  // signed operator output
`define OPL_NUM_PAIRS     3   // four-operator connection bits

`endif

// File: hdl/opl_slot_pkg.sv
// shared types: channel and operator registers, operator output,
// slot index, per-slot control and Wishbone request/response
`include "opl_slot_config.svh"

package opl_slot_pkg;

    typedef logic signed [`OPL_OUT_W-1:0] op_out_t;

    typedef logic [$clog2(`OPL_NUM_SLOTS)-1:0] slot_idx_t;

    // field order matches the register map, cnt on top
    typedef struct packed {
        logic                    cnt;
        logic [`OPL_FB_W-1:0]    fb;
        logic                    kon;
        logic [`OPL_BLOCK_W-1:0] block;
        logic [`OPL_FNUM_W-1:0]  fnum;
    } chan_reg_t;

    typedef struct packed {
        logic [`OPL_MULT_W-1:0] mult;
    } op_reg_t;

    typedef struct packed {
        logic [`OPL_FNUM_W-1:0]  fnum;
        logic [`OPL_BLOCK_W-1:0] block;
        logic [`OPL_MULT_W-1:0]  mult;
        logic                    kon;
        logic [`OPL_FB_W-1:0]    fb;  // zero on slots without feedback
        logic                    use_feedback;
        op_out_t                 modulation;
    } slot_ctrl_t;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [7:0]  adr;
        logic [31:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

// File: hdl/opl_reg_block.sv
// Wishbone classic slave: channel registers, operator mult registers,
// connection select, and read-back of captured slot outputs
`timescale 1ns/1ps
`include "opl_slot_config.svh"

module opl_reg_block (
    input  logic                  clk,
    input  logic                  arst_n,
    input  opl_slot_pkg::wb_req_t wb_req,
    output opl_slot_pkg::wb_rsp_t wb_rsp,
    input  opl_slot_pkg::op_out_t op_out [`OPL_NUM_SLOTS],
    output opl_slot_pkg::chan_reg_t chan_regs [`OPL_NUM_CHANNELS],
    output opl_slot_pkg::op_reg_t op_regs [`OPL_NUM_SLOTS],
    output logic [`OPL_NUM_PAIRS-1:0] connection_sel
);
    import opl_slot_pkg::*;

    localparam logic [7:0] CHAN_BASE = 8'd0;
    localparam logic [7:0] MULT_BASE = 8'd16;
    localparam logic [7:0] CONN_ADDR = 8'd40;
    localparam logic [7:0] OUT_BASE  = 8'd64;

    logic        ack_q;
    logic        served;   // strobe already answered
    logic        req_new;
    logic [31:0] rd_data;
    logic [31:0] dat_r_q;

    assign req_new = wb_req.cyc && wb_req.stb && !served;

    always_comb begin
        rd_data = '0;
        for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
            if (wb_req.adr == CHAN_BASE + 8'(i))
                rd_data[$bits(chan_reg_t)-1:0] = chan_regs[i];
        end
        for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
            if (wb_req.adr == MULT_BASE + 8'(i))
                rd_data[`OPL_MULT_W-1:0] = op_regs[i].mult;
            if (wb_req.adr == OUT_BASE + 8'(i))  // sign-extended capture
                rd_data = {{(32-`OPL_OUT_W){op_out[i][`OPL_OUT_W-1]}}, op_out[i]};
        end
        if (wb_req.adr == CONN_ADDR)
            rd_data[`OPL_NUM_PAIRS-1:0] = connection_sel;
    end

    // one ack per strobe, read data registered alongside
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q   <= 1'b0;
            served  <= 1'b0;
            dat_r_q <= '0;
        end else begin
            ack_q  <= req_new;
            served <= (wb_req.cyc && wb_req.stb) ? (served || req_new) : 1'b0;
            if (req_new && !wb_req.we)
                dat_r_q <= rd_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++)
                chan_regs[i] <= '0;
            for (int i = 0; i < `OPL_NUM_SLOTS; i++)
                op_regs[i] <= '0;
            connection_sel <= '0;
        end else if (req_new && wb_req.we) begin
            for (int i = 0; i < `OPL_NUM_CHANNELS; i++) begin
                if (wb_req.adr == CHAN_BASE + 8'(i))
                    chan_regs[i] <= chan_reg_t'(wb_req.dat_w[$bits(chan_reg_t)-1:0]);
            end
            for (int i = 0; i < `OPL_NUM_SLOTS; i++) begin
                if (wb_req.adr == MULT_BASE + 8'(i))
                    op_regs[i].mult <= wb_req.dat_w[`OPL_MULT_W-1:0];
            end
            if (wb_req.adr == CONN_ADDR)
                connection_sel <= wb_req.dat_w[`OPL_NUM_PAIRS-1:0];
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

endmodule

// File: hdl/slot_sequencer.sv
// slot sequencer: idle/slot FSM, window counter,
// slot start and capture strobes, end-of-sample pulse
`timescale 1ns/1ps
`include "opl_slot_config.svh"

module slot_sequencer (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    sample_en,
    output opl_slot_pkg::slot_idx_t slot,
    output logic                    slot_start,
    output logic                    capture,
    output logic                    sample_done
);
    import opl_slot_pkg::*;

    localparam int CNT_W = $clog2(`OPL_SLOT_CYCLES);
    localparam slot_idx_t LAST_SLOT = slot_idx_t'(`OPL_NUM_SLOTS - 1);

    typedef enum logic {IDLE, SLOT} state_e;

    state_e           state;
    logic [CNT_W-1:0] win_cnt;  // position inside the slot window
    logic             win_end;

    assign win_end = (win_cnt == CNT_W'(`OPL_SLOT_CYCLES - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= IDLE;
            slot        <= '0;
            win_cnt     <= '0;
            sample_done <= 1'b0;
        end else begin
            sample_done <= 1'b0;
            case (state)
                IDLE: begin
                    if (sample_en) begin
                        state   <= SLOT;
                        slot    <= '0;
                        win_cnt <= '0;
                    end
                end
                SLOT: begin
                    if (win_end) begin
                        win_cnt <= '0;
                        if (slot == LAST_SLOT) begin
                            state       <= IDLE;
                            sample_done <= 1'b1;
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end else begin
                        win_cnt <= win_cnt + 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    assign slot_start = (state == SLOT) && (win_cnt == '0);
    assign capture    = (state == SLOT) && win_end;  // operator output stable by now

endmodule

// File: hdl/slot_router.sv
// slot router: channel, feedback use and modulation source per slot,
// covering two-operator pairs and the three four-operator chains
`timescale 1ns/1ps
`include "opl_slot_config.svh"

module slot_router (
    input  opl_slot_pkg::slot_idx_t  slot,
    input  opl_slot_pkg::chan_reg_t  chan_regs [`OPL_NUM_CHANNELS],
    input  opl_slot_pkg::op_reg_t    op_regs [`OPL_NUM_SLOTS],
    input  logic [`OPL_NUM_PAIRS-1:0] connection_sel,
    input  opl_slot_pkg::op_out_t    op_out [`OPL_NUM_SLOTS],
    output opl_slot_pkg::slot_ctrl_t ctrl
);
    import opl_slot_pkg::*;

    logic [$clog2(`OPL_NUM_CHANNELS)-1:0] chan;
    logic                                  use_fb;
    op_out_t                               mod;
    chan_reg_t                             ch_reg;

    always_comb begin
        chan   = '0;
        use_fb = 1'b0;
        mod    = '0;
        for (int k = 0; k < `OPL_NUM_PAIRS; k++) begin
            if (slot == slot_idx_t'(k)) begin  // first modulators, channels 0-2
                chan   = 4'(k);
                use_fb = 1'b1;
            end
            if (slot == slot_idx_t'(3 + k)) begin
                chan = 4'(k);
                mod  = chan_regs[k].cnt ? '0 : op_out[k];
            end
            if (slot == slot_idx_t'(12 + k)) begin  // channels 6-8
                chan   = 4'(6 + k);
                use_fb = 1'b1;
            end
            if (slot == slot_idx_t'(15 + k)) begin
                chan = 4'(6 + k);
                mod  = chan_regs[6 + k].cnt ? '0 : op_out[12 + k];
            end
            if (slot == slot_idx_t'(6 + k)) begin
                if (connection_sel[k]) begin  // third op of a 4-op chain
                    chan = 4'(k);
                    mod  = (!chan_regs[k].cnt && chan_regs[3 + k].cnt) ? '0 : op_out[3 + k];
                end else begin
                    chan   = 4'(3 + k);
                    use_fb = 1'b1;
                end
            end
            if (slot == slot_idx_t'(9 + k)) begin
                if (connection_sel[k]) begin  // last op of the chain
                    chan = 4'(k);
                    mod  = (chan_regs[k].cnt && chan_regs[3 + k].cnt) ? '0 : op_out[6 + k];
                end else begin
                    chan = 4'(3 + k);
                    mod  = chan_regs[3 + k].cnt ? '0 : op_out[6 + k];
                end
            end
        end
    end

    assign ch_reg = chan_regs[chan];

    assign ctrl = '{
        fnum:         ch_reg.fnum,
        block:        ch_reg.block,
        mult:         op_regs[slot].mult,
        kon:          ch_reg.kon,
        fb:           use_fb ? ch_reg.fb : `OPL_FB_W'(0),
        use_feedback: use_fb,
        modulation:   mod
    };

endmodule

// File: hdl/phase_operator.sv
// shared operator: per-slot phase accumulators and a three-stage
// output pipeline adding modulation and feedback
`timescale 1ns/1ps
`include "opl_slot_config.svh"

module phase_operator (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     slot_start,
    input  opl_slot_pkg::slot_idx_t  slot,
    input  opl_slot_pkg::slot_ctrl_t ctrl,
    input  opl_slot_pkg::op_out_t    prev_out,
    output opl_slot_pkg::op_out_t    out
);
    import opl_slot_pkg::*;

    logic [`OPL_PHASE_W-1:0] phase [`OPL_NUM_SLOTS];
    logic [`OPL_PHASE_W-1:0] fnum_shift;
    logic [`OPL_PHASE_W-1:0] step;
    logic [`OPL_PHASE_W-1:0] phase_sum;
    op_out_t                 fb_term;

    logic                    s1_valid;
    slot_ctrl_t              s1_ctrl;
    slot_idx_t               s1_slot;
    logic [`OPL_PHASE_W-1:0] s1_step;
    op_out_t                 s1_fb;

    logic                    s2_valid;
    logic                    s2_kon;
    op_out_t                 s2_top;
    op_out_t                 s2_mod;
    op_out_t                 s2_fb;

    assign fnum_shift = `OPL_PHASE_W'(ctrl.fnum) << ctrl.block;
    assign step       = fnum_shift * `OPL_PHASE_W'(ctrl.mult);  // wraps at phase width
    assign fb_term    = (ctrl.use_feedback && ctrl.fb != '0) ?
                        op_out_t'(prev_out >>> (4'd8 - 4'(ctrl.fb))) : '0;
    assign phase_sum  = phase[s1_slot] + s1_step;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            for (int i = 0; i < `OPL_NUM_SLOTS; i++)
                phase[i] <= '0;
        end else begin
            s1_valid <= slot_start;
            s2_valid <= s1_valid;
            if (s1_valid)
                phase[s1_slot] <= s1_ctrl.kon ? phase_sum : '0;  // key off clears
        end
    end

    always_ff @(posedge clk) begin
        if (slot_start) begin
            s1_ctrl <= ctrl;
            s1_slot <= slot;
            s1_step <= step;
            s1_fb   <= fb_term;
        end
        if (s1_valid) begin
            s2_kon <= s1_ctrl.kon;
            s2_top <= phase_sum[`OPL_PHASE_W-1 -: `OPL_OUT_W];
            s2_mod <= s1_ctrl.modulation;
            s2_fb  <= s1_fb;
        end
        if (s2_valid)
            out <= s2_kon ? s2_top + s2_mod + s2_fb : '0;  // held until next slot
    end

endmodule

// File: hdl/op_output_store.sv
// captured operator outputs, one entry per slot,
// with the current slot's old value presented for feedback
`timescale 1ns/1ps
`include "opl_slot_config.svh"

module op_output_store (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    capture,
    input  opl_slot_pkg::slot_idx_t slot,
    input  opl_slot_pkg::op_out_t   out_in,
    output opl_slot_pkg::op_out_t   op_out [`OPL_NUM_SLOTS],
    output opl_slot_pkg::op_out_t   prev_out
);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `OPL_NUM_SLOTS; i++)
                op_out[i] <= '0;
        end else if (capture) begin
            op_out[slot] <= out_in;  // end of the slot window
        end
    end

    // last sample's value until this slot's capture
    assign prev_out = op_out[slot];

endmodule

// File: hdl/opl_slot_core.sv
// top level of the FM operator slot engine: register block,
// sequencer, router, shared operator and output store
`timescale 1ns/1ps
`include "opl_slot_config.svh"

module opl_slot_core (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  sample_en,
    input  opl_slot_pkg::wb_req_t wb_req,
    output opl_slot_pkg::wb_rsp_t wb_rsp,
    output logic                  sample_done
);
    import opl_slot_pkg::*;

    chan_reg_t                 chan_regs [`OPL_NUM_CHANNELS];
    op_reg_t                   op_regs [`OPL_NUM_SLOTS];
    logic [`OPL_NUM_PAIRS-1:0] connection_sel;
    op_out_t                   op_out [`OPL_NUM_SLOTS];
    op_out_t                   prev_out;
    op_out_t                   op_res;  // operator result for the current slot
    slot_idx_t                 slot;
    slot_ctrl_t                ctrl;
    logic                      slot_start;
    logic                      capture;

    opl_reg_block u_regs (
        .clk, .arst_n, .wb_req, .wb_rsp, .op_out, .chan_regs, .op_regs, .connection_sel
    );

    slot_sequencer u_seq (
        .clk, .arst_n, .sample_en, .slot, .slot_start, .capture, .sample_done
    );

    slot_router u_router (
        .slot, .chan_regs, .op_regs, .connection_sel, .op_out, .ctrl
    );

    phase_operator u_op (
        .clk, .arst_n, .slot_start, .slot, .ctrl, .prev_out, .out(op_res)
    );

    op_output_store u_store (
        .clk, .arst_n, .capture, .slot, .out_in(op_res), .op_out, .prev_out
    );

endmodule

// File: verification/opl_slot_core_tb.sv
// testbench for the FM operator slot engine: clock and reset,
// Wishbone access tasks, reference model of routing and operator,
// directed tests and a watchdog
`timescale 1ns/1ps
`include "opl_slot_config.svh"

module opl_slot_core_tb;
    import opl_slot_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int SAMPLE_CYCLES = `OPL_SLOT_CYCLES * `OPL_NUM_SLOTS;
    localparam int NUM_TESTS     = 6;
    localparam int MAX_SAMPLES   = 12;  // samples in the four-op chain test
    localparam int WATCHDOG_CYCLES = NUM_TESTS * MAX_SAMPLES * (2 * SAMPLE_CYCLES + 256) + 2000;
    localparam int ACK_LIMIT     = 8;

    logic    clk = 1'b0;
    logic    arst_n;
    logic    sample_en;
    wb_req_t wb_req;
    wb_rsp_t wb_rsp;
    logic    sample_done;

    // model copies of the registers
    logic [`OPL_FNUM_W-1:0]    m_fnum  [`OPL_NUM_CHANNELS];
    logic [`OPL_BLOCK_W-1:0]   m_block [`OPL_NUM_CHANNELS];
    logic                      m_kon   [`OPL_NUM_CHANNELS];
    logic [`OPL_FB_W-1:0]      m_fb    [`OPL_NUM_CHANNELS];
    logic                      m_cnt   [`OPL_NUM_CHANNELS];
    logic [`OPL_MULT_W-1:0]    m_mult  [`OPL_NUM_SLOTS];
    logic [`OPL_NUM_PAIRS-1:0] m_conn;
    // model operator state
    logic [`OPL_PHASE_W-1:0]      m_phase [`OPL_NUM_SLOTS];
    logic signed [`OPL_OUT_W-1:0] m_out   [`OPL_NUM_SLOTS];

    logic [31:0] lfsr = 32'd87388;
    int errors       = 0;
    int checks       = 0;
    int tests_run    = 0;
    int tests_failed = 0;

    opl_slot_core uut (
        .clk, .arst_n, .sample_en, .wb_req, .wb_rsp, .sample_done
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired before the tests completed");
        $display("TEST FAILED");
        $finish;
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);  // one step per bit
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    // strobe held a cycle past ack to catch a second ack
    task automatic wb_access(input logic we, input logic [7:0] adr, input logic [31:0] wdat,
                             output logic [31:0] rdat);
        wb_req_t req;
        int      waited;
        req.cyc   = 1'b1;
        req.stb   = 1'b1;
        req.we    = we;
        req.adr   = adr;
        req.dat_w = wdat;
        waited    = 0;
        @(posedge clk);
        wb_req <= req;
        @(negedge clk);
        while (!wb_rsp.ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!wb_rsp.ack) begin
            errors++;
            $display("no Wishbone ack for address 0x%02h", adr);
        end
        compare("ack latency", waited, 32'd1);
        rdat = wb_rsp.dat_r;
        @(negedge clk);
        if (wb_rsp.ack) begin
            errors++;
            $display("second ack while strobe held at address 0x%02h", adr);
        end
        @(posedge clk);
        wb_req <= '0;
    endtask

    task automatic wb_write(input logic [7:0] adr, input logic [31:0] data);
        logic [31:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [7:0] adr, output logic [31:0] data);
        wb_access(1'b0, adr, 32'd0, data);
    endtask

    task automatic set_chan_raw(input int ch, input logic [31:0] v);
        m_fnum[ch]  = v[9:0];
        m_block[ch] = v[12:10];
        m_kon[ch]   = v[13];
        m_fb[ch]    = v[16:14];
        m_cnt[ch]   = v[17];
        wb_write(8'(ch), v);
    endtask

    task automatic set_chan(input int ch, input logic [9:0] fnum, input logic [2:0] block,
                            input logic kon, input logic [2:0] fb, input logic cnt);
        set_chan_raw(ch, {14'd0, cnt, fb, kon, block, fnum});
    endtask

    task automatic set_mult(input int s, input logic [3:0] mult);
        m_mult[s] = mult;
        wb_write(8'(16 + s), {28'd0, mult});
    endtask

    task automatic set_conn(input logic [2:0] conn);
        m_conn = conn;
        wb_write(8'd40, {29'd0, conn});
    endtask

    task automatic randomize_regs(input logic kon, input logic cnt, input logic fb_nonzero);
        logic [31:0] fnum;
        logic [31:0] block;
        logic [31:0] fb;
        logic [31:0] mult;
        for (int ch = 0; ch < `OPL_NUM_CHANNELS; ch++) begin
            rand_bits(10, fnum);
            rand_bits(3, block);
            rand_bits(3, fb);
            if (fb_nonzero && fb[2:0] == 3'd0)
                fb = 32'd7;
            set_chan(ch, fnum[9:0], block[2:0], kon, fb[2:0], cnt);
        end
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            rand_bits(4, mult);
            set_mult(s, mult[3:0]);
        end
    endtask

    // channel, feedback use and modulation of one slot
    task automatic route_slot(input int s, output int ch, output logic use_fb,
                              output logic signed [`OPL_OUT_W-1:0] mod);
        int k;
        k      = s % 3;
        ch     = 0;
        use_fb = 1'b0;
        mod    = '0;
        if (s < 3) begin
            ch     = k;
            use_fb = 1'b1;
        end else if (s < 6) begin
            ch  = k;
            mod = m_cnt[k] ? '0 : m_out[k];
        end else if (s < 12 && m_conn[k]) begin  // four-op chain on channel k
            ch = k;
            if (s < 9)
                mod = (!m_cnt[k] && m_cnt[3 + k]) ? '0 : m_out[3 + k];
            else
                mod = (m_cnt[k] && m_cnt[3 + k]) ? '0 : m_out[6 + k];
        end else if (s < 12) begin
            ch = 3 + k;
            if (s < 9)
                use_fb = 1'b1;
            else
                mod = m_cnt[3 + k] ? '0 : m_out[6 + k];
        end else if (s < 15) begin
            ch     = 6 + k;
            use_fb = 1'b1;
        end else begin
            ch  = 6 + k;
            mod = m_cnt[6 + k] ? '0 : m_out[12 + k];
        end
    endtask

    task automatic model_sample();
        int                           ch;
        logic                         use_fb;
        logic signed [`OPL_OUT_W-1:0] mod;
        logic signed [`OPL_OUT_W-1:0] fbt;
        logic [`OPL_PHASE_W-1:0]      step;
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            route_slot(s, ch, use_fb, mod);
            fbt = '0;
            if (use_fb && m_fb[ch] != 3'd0)
                fbt = m_out[s] >>> (8 - m_fb[ch]);  // last sample's capture
            if (!m_kon[ch]) begin
                m_phase[s] = '0;
                m_out[s]   = '0;
            end else begin
                step       = 20'((32'(m_fnum[ch]) << m_block[ch]) * 32'(m_mult[s]));
                m_phase[s] = m_phase[s] + step;
                m_out[s]   = m_phase[s][19:8] + mod + fbt;
            end
        end
    endtask

    task automatic run_sample(input logic busy_pulse);
        int cycles;
        @(posedge clk);
        sample_en <= 1'b1;
        @(posedge clk);  // sequencer takes the request here
        sample_en <= 1'b0;
        @(negedge clk);  // slot 0, window count 0
        cycles = 0;
        while (!sample_done && cycles <= SAMPLE_CYCLES + 20) begin
            @(posedge clk);
            sample_en <= busy_pulse && cycles == 40;
            @(negedge clk);
            cycles++;
        end
        if (!sample_done) begin
            errors++;
            $display("sample_done did not arrive within %0d cycles", cycles);
        end
        compare("sample length", cycles, SAMPLE_CYCLES);
        model_sample();
    endtask

    task automatic verify_outputs();
        logic [31:0] rd;
        logic [31:0] exp;
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            wb_read(8'(64 + s), rd);
            exp = {{(32 - `OPL_OUT_W){m_out[s][`OPL_OUT_W-1]}}, m_out[s]};
            compare($sformatf("out[%0d]", s), rd, exp);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic register_access();
        logic [7:0]  unmapped [7] = '{8'd9, 8'd12, 8'd34, 8'd39, 8'd41, 8'd63, 8'd82};
        logic [31:0] v;
        logic [31:0] rd;
        int          e0;
        e0 = errors;
        for (int ch = 0; ch < `OPL_NUM_CHANNELS; ch++) begin
            rand_bits(32, v);
            set_chan_raw(ch, v);
            wb_read(8'(ch), rd);
            compare($sformatf("chan[%0d]", ch), rd, v & 32'h3_FFFF);
        end
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            rand_bits(32, v);
            m_mult[s] = v[3:0];
            wb_write(8'(16 + s), v);
            wb_read(8'(16 + s), rd);
            compare($sformatf("mult[%0d]", s), rd, v & 32'hF);
        end
        rand_bits(32, v);
        m_conn = v[2:0];
        wb_write(8'd40, v);
        wb_read(8'd40, rd);
        compare("connection_sel", rd, v & 32'h7);
        wb_write(8'd12, 32'hFFFF_FFFF);  // unmapped, ignored
        foreach (unmapped[i]) begin
            wb_read(unmapped[i], rd);
            compare($sformatf("unmapped 0x%02h", unmapped[i]), rd, 32'd0);
        end
        wb_read(8'd255, rd);
        compare("unmapped 0xff", rd, 32'd0);
        report_test("register access", e0);
    endtask

    task automatic key_off_state();
        int e0;
        e0 = errors;
        verify_outputs();  // reset values
        set_conn(3'd0);
        for (int ch = 0; ch < `OPL_NUM_CHANNELS; ch++)
            set_chan(ch, 10'h3FF, 3'd7, 1'b0, 3'd7, 1'b0);
        run_sample(1'b0);
        verify_outputs();
        report_test("key off and reset state", e0);
    endtask

    task automatic two_op_pairs();
        int e0;
        e0 = errors;
        set_conn(3'd0);
        for (int c = 0; c < 2; c++) begin
            randomize_regs(1'b1, c[0], 1'b0);
            repeat (3) begin
                run_sample(1'b0);
                verify_outputs();
            end
        end
        report_test("two-operator pairs", e0);
    endtask

    task automatic four_op_chains();
        int e0;
        e0 = errors;
        for (int k = 0; k < `OPL_NUM_PAIRS; k++) begin
            set_conn(3'(1 << k));
            randomize_regs(1'b1, 1'b0, 1'b0);
            for (int combo = 0; combo < 4; combo++) begin
                set_chan(k, m_fnum[k], m_block[k], 1'b1, m_fb[k], combo[0]);
                set_chan(3 + k, m_fnum[3 + k], m_block[3 + k], 1'b1, m_fb[3 + k], combo[1]);
                run_sample(1'b0);
                verify_outputs();
            end
        end
        report_test("four-operator chains", e0);
    endtask

    task automatic feedback_run();
        int e0;
        e0 = errors;
        set_conn(3'd0);
        randomize_regs(1'b1, 1'b0, 1'b1);
        repeat (4) begin
            run_sample(1'b0);
            verify_outputs();
        end
        report_test("feedback accumulation", e0);
    endtask

    task automatic busy_sample_en();
        int extra;
        int e0;
        e0    = errors;
        extra = 0;
        randomize_regs(1'b1, 1'b0, 1'b0);
        run_sample(1'b1);  // second request mid-sample
        repeat (SAMPLE_CYCLES + 10) begin
            @(negedge clk);
            if (sample_done)
                extra++;
        end
        compare("extra sample_done", extra, 32'd0);
        verify_outputs();
        report_test("busy sample_en", e0);
    endtask

    initial begin
        arst_n    = 1'b0;
        sample_en = 1'b0;
        wb_req    = '0;
        m_conn    = '0;
        for (int s = 0; s < `OPL_NUM_SLOTS; s++) begin
            m_phase[s] = '0;
            m_out[s]   = '0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        register_access();
        key_off_state();
        two_op_pairs();
        four_op_chains();
        feedback_run();
        busy_sample_en();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

// File: opl_slot_core.f
+incdir+.
hdl/opl_slot_pkg.sv
hdl/opl_reg_block.sv
hdl/slot_sequencer.sv
hdl/slot_router.sv
hdl/phase_operator.sv
hdl/op_output_store.sv
hdl/opl_slot_core.sv
verification/opl_slot_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= opl_slot_core_tb
FILELIST  ?= opl_slot_core.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
LOG       ?= sim.log
PASS_MSG  ?= TEST OK

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) opl_slot_config.svh
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
